// ==== source/obi_mon_pkg.sv ====
package obi_mon_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------

  // width of the outstanding address-phase counter
  localparam int unsigned OUTST_W = 4;

  // the counter stops at this value instead of wrapping back to zero
  localparam logic [OUTST_W-1:0] OUTST_MAX = '1;

  // number of OBI links watched by the top level
  localparam int unsigned NUM_LINKS = 5;

  // ----------------------------------------
  // link naming
  // ----------------------------------------

  // array index of each watched link in links_i and phases_o
  // abiim is alignment buffer to instruction MPU, lml is LSU to its MPU,
  // lrfodi is LSU response filter to OBI data interface
  typedef enum logic [2:0] {
    LINK_DATA   = 3'd0,
    LINK_INSTR  = 3'd1,
    LINK_ABIIM  = 3'd2,
    LINK_LML    = 3'd3,
    LINK_LRFODI = 3'd4
  } obi_link_e;

  // ----------------------------------------
  // bus types
  // ----------------------------------------

  // the handshake signals of one link, as seen from the side
  typedef struct packed {
    logic req;
    logic gnt;
    logic rvalid;
    logic rready;
  } obi_link_t;

  // per-link result registered one cycle after the observed bus cycle
  typedef struct packed {
    logic               addr_ph_cont;
    logic               resp_ph_cont;
    logic [OUTST_W-1:0] addr_ph_cnt;
  } obi_phase_t;

endpackage

// ==== source/core_ctrl_pkg.sv ====
package core_ctrl_pkg;

  // ----------------------------------------
  // program counter source
  // ----------------------------------------

  // width of the pc mux select coming out of the controller
  localparam int unsigned PC_MUX_W = 3;

  // where the controller takes the next pc from when pc_set is high
  // only the exception and debug-entry traps matter to the trap tracker
  typedef enum logic [PC_MUX_W-1:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_DBE = 3'd5,
    PC_TRAP_IRQ = 3'd6,
    PC_DRET     = 3'd7
  } pc_mux_e;

  // ----------------------------------------
  // controller observation
  // ----------------------------------------

  // pc_set is the jump strobe of the controller in the writeback stage
  // pc_mux qualifies that strobe and is ignored while pc_set is low
  // retire_valid pulses once for every instruction that retires
  typedef struct packed {
    logic    pc_set;
    pc_mux_e pc_mux;
    logic    retire_valid;
  } ctrl_obs_t;

endpackage

// ==== source/obi_phases_monitor.sv ====
module obi_phases_monitor (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  obi_mon_pkg::obi_link_t  link_i,
  output obi_mon_pkg::obi_phase_t phase_o
);

  import obi_mon_pkg::*;

  // ----------------------------------------
  // phase decode
  // ----------------------------------------

  // an address phase completes when the request is granted
  logic addr_ph;
  // a response phase completes when the response is accepted
  logic resp_ph;

  logic               addr_ph_cont_q;
  logic               resp_ph_cont_q;
  logic [OUTST_W-1:0] addr_ph_cnt_q;

  assign addr_ph = link_i.req & link_i.gnt;
  assign resp_ph = link_i.rvalid & link_i.rready;

  // ----------------------------------------
  // continuation indicators
  // ----------------------------------------

  // a request left waiting for gnt, or a response left waiting for rready,
  // means the phase carries over into the next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_ph_cont_q <= 1'b0;
      resp_ph_cont_q <= 1'b0;
    end else begin
      addr_ph_cont_q <= link_i.req & ~link_i.gnt;
      resp_ph_cont_q <= link_i.rvalid & ~link_i.rready;
    end
  end

  // ----------------------------------------
  // outstanding address phases
  // ----------------------------------------

  // counts granted requests that have not been answered yet
  // an address and a response phase in the same cycle cancel out
  // the count holds at its maximum and never drops below zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_ph_cnt_q <= '0;
    end else begin
      if (addr_ph && !resp_ph && (addr_ph_cnt_q != OUTST_MAX)) begin
        addr_ph_cnt_q <= addr_ph_cnt_q + 1'b1;
      end else if (!addr_ph && resp_ph && (addr_ph_cnt_q != '0)) begin
        addr_ph_cnt_q <= addr_ph_cnt_q - 1'b1;
      end
    end
  end

  // pack the registered results for the consumer
  assign phase_o.addr_ph_cont = addr_ph_cont_q;
  assign phase_o.resp_ph_cont = resp_ph_cont_q;
  assign phase_o.addr_ph_cnt  = addr_ph_cnt_q;

endmodule

// ==== source/trap_req_tracker.sv ====
module trap_req_tracker (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  obi_mon_pkg::obi_link_t   data_link_i,
  input  core_ctrl_pkg::ctrl_obs_t ctrl_i,
  output logic                     req_after_trap_o
);

  import core_ctrl_pkg::*;

  // ----------------------------------------
  // trap decode
  // ----------------------------------------

  // only synchronous exceptions and debug entry count as a trap here
  // interrupts and plain jumps do not open the window
  logic trap_taken;
  // a new data request right after an address phase finished last cycle
  logic new_req;

  // data gnt delayed by one cycle
  logic data_gnt_q;
  // high from the trap until the next instruction retires
  logic trap_active_q;
  logic req_after_trap_q;

  assign trap_taken = ctrl_i.pc_set &&
                      ((ctrl_i.pc_mux == PC_TRAP_EXC) || (ctrl_i.pc_mux == PC_TRAP_DBE));

  assign new_req = data_link_i.req & data_gnt_q;

  // ----------------------------------------
  // trap window and flag
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_gnt_q       <= 1'b0;
      trap_active_q    <= 1'b0;
      req_after_trap_q <= 1'b0;
    end else begin
      data_gnt_q <= data_link_i.gnt;

      if (trap_taken) begin
        // the window opens, and a request in this very cycle already counts
        trap_active_q <= 1'b1;
        if (new_req) begin
          req_after_trap_q <= 1'b1;
        end
      end else if (ctrl_i.retire_valid) begin
        // the trapping instruction has retired so the window closes
        trap_active_q    <= 1'b0;
        req_after_trap_q <= 1'b0;
      end else if (trap_active_q && new_req) begin
        req_after_trap_q <= 1'b1;
      end
    end
  end

  // the flag stays up until retirement clears it
  assign req_after_trap_o = req_after_trap_q;

endmodule

// ==== source/obs_support_logic.sv ====
module obs_support_logic (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  // observed handshake of every link, indexed by obi_link_e
  input  obi_mon_pkg::obi_link_t  [obi_mon_pkg::NUM_LINKS-1:0] links_i,
  // controller jump strobe and retire strobe
  input  core_ctrl_pkg::ctrl_obs_t                            ctrl_i,
  // per-link phase results, same indexing as links_i
  output obi_mon_pkg::obi_phase_t [obi_mon_pkg::NUM_LINKS-1:0] phases_o,
  // data request seen between a trap and the next retirement
  output logic                                                req_after_trap_o
);

  import obi_mon_pkg::*;

  // ----------------------------------------
  // per-link phase monitors
  // ----------------------------------------

  // one monitor for each link, from the data bus up to the
  // LSU response filter link
  // every output is registered, so results lag the bus by one cycle
  for (genvar g = int'(LINK_DATA); g <= int'(LINK_LRFODI); g++) begin : gen_link_mon
    obi_phases_monitor i_phase_mon (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .link_i  (links_i[g]),
      .phase_o (phases_o[g])
    );
  end

  // ----------------------------------------
  // trap tracking on the data bus
  // ----------------------------------------

  // only the data bus matters for requests issued after a trap
  // the instruction side is free to keep fetching
  trap_req_tracker i_trap_tracker (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .data_link_i      (links_i[LINK_DATA]),
    .ctrl_i           (ctrl_i),
    .req_after_trap_o (req_after_trap_o)
  );

endmodule

// ==== tb/tb_obs_support_logic.sv ====
module tb_obs_support_logic;

  timeunit 1ns;
  timeprecision 100ps;

  import obi_mon_pkg::*;
  import core_ctrl_pkg::*;

  // ----------------------------------------
  // constants and types
  // ----------------------------------------

  localparam int    CLK_PERIOD   = 4;
  localparam int    RESET_CYCLES = 4;
  localparam string VECTOR_FILE  = "tb/obs_vectors.txt";

  // same shapes as the ports of the DUT
  typedef obi_link_t  [NUM_LINKS-1:0] link_vec_t;
  typedef obi_phase_t [NUM_LINKS-1:0] phase_vec_t;

  // ----------------------------------------
  // DUT signals and vector storage
  // ----------------------------------------

  logic       clk;
  logic       rst_n;
  link_vec_t  links;
  ctrl_obs_t  ctrl;
  phase_vec_t phases;
  logic       req_after_trap;

  // one entry per vector line and all queues share the same index
  string      name_q[$];
  link_vec_t  link_q[$];
  ctrl_obs_t  ctrl_q[$];
  phase_vec_t exp_phase_q[$];
  logic       exp_flag_q[$];

  // tells the watchdog that the vector count is known
  bit         vectors_loaded;

  obs_support_logic i_dut (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .links_i          (links),
    .ctrl_i           (ctrl),
    .phases_o         (phases),
    .req_after_trap_o (req_after_trap)
  );

  // free running clock whose first rising edge comes half a period in
  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // ----------------------------------------
  // failure and compare tasks
  // ----------------------------------------

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped after the first failure");
  endtask

  // compares the phase result of one link
  task automatic check_phase(input string test, input obi_link_e link,
                             input obi_phase_t exp, input obi_phase_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf(
        "error: test %s link %s expected cont %b%b cnt %0d actual cont %b%b cnt %0d",
        test, link.name(), exp.addr_ph_cont, exp.resp_ph_cont, exp.addr_ph_cnt,
        act.addr_ph_cont, act.resp_ph_cont, act.addr_ph_cnt));
    end
  endtask

  // compares the request-after-trap flag
  task automatic check_flag(input string test, input logic exp, input logic act);
    if (act !== exp) begin
      stop_with_failure($sformatf("error: test %s req_after_trap expected %b actual %b",
                                  test, exp, act));
    end
  endtask

  // walks every link by its enum name, then checks the tracker flag
  task automatic check_outputs(input int k);
    obi_link_e link;
    link = link.first();
    repeat (NUM_LINKS) begin
      check_phase(name_q[k], link, exp_phase_q[k][link], phases[link]);
      link = link.next();
    end
    check_flag(name_q[k], exp_flag_q[k], req_after_trap);
  endtask

  // every register of the DUT reads zero while reset is held
  task automatic check_reset_state();
    obi_link_e link;
    link = link.first();
    repeat (NUM_LINKS) begin
      check_phase("reset", link, '0, phases[link]);
      link = link.next();
    end
    check_flag("reset", 1'b0, req_after_trap);
  endtask

  // ----------------------------------------
  // vector file reader
  // ----------------------------------------

  // a line starting with # is skipped up to its end
  // link fields are req gnt rvalid rready in binary
  // expected phases are two hex digits holding {addr_cont, resp_cont} and then the count
  task automatic load_vectors();
    int         fd;
    int         code;
    string      token;
    string      rest;
    logic [3:0] link_bits  [NUM_LINKS];
    logic [5:0] phase_bits [NUM_LINKS];
    logic       pc_set_bit;
    int         mux_val;
    logic       retire_bit;
    logic       flag_bit;
    link_vec_t  lv;
    ctrl_obs_t  cv;
    phase_vec_t pv;
    obi_link_e  link;
    fd = $fopen(VECTOR_FILE, "r");
    if (fd == 0) begin
      stop_with_failure("could not open the vector file tb/obs_vectors.txt");
    end else begin
      code = $fscanf(fd, "%s", token);
      while (code == 1) begin
        if (token.substr(0, 0) == "#") begin
          code = $fgets(rest, fd);
        end else begin
          code = $fscanf(fd, "%b %b %b %b %b %b %d %b %h %h %h %h %h %b",
                         link_bits[LINK_DATA], link_bits[LINK_INSTR],
                         link_bits[LINK_ABIIM], link_bits[LINK_LML],
                         link_bits[LINK_LRFODI], pc_set_bit, mux_val, retire_bit,
                         phase_bits[LINK_DATA], phase_bits[LINK_INSTR],
                         phase_bits[LINK_ABIIM], phase_bits[LINK_LML],
                         phase_bits[LINK_LRFODI], flag_bit);
          if (code != 14) begin
            stop_with_failure($sformatf("vector line %s has missing or bad fields", token));
          end
          link = link.first();
          repeat (NUM_LINKS) begin
            lv[link] = obi_link_t'(link_bits[link]);
            pv[link] = obi_phase_t'(phase_bits[link]);
            link = link.next();
          end
          cv.pc_set       = pc_set_bit;
          cv.pc_mux       = pc_mux_e'(mux_val[PC_MUX_W-1:0]);
          cv.retire_valid = retire_bit;
          name_q.push_back(token);
          link_q.push_back(lv);
          ctrl_q.push_back(cv);
          exp_phase_q.push_back(pv);
          exp_flag_q.push_back(flag_bit);
        end
        code = $fscanf(fd, "%s", token);
      end
      $fclose(fd);
      if (name_q.size() == 0) begin
        stop_with_failure("the vector file holds no vectors");
      end
    end
  endtask

  // ----------------------------------------
  // watchdog
  // ----------------------------------------

  // two clock periods per vector plus headroom for reset
  initial begin
    realtime limit;
    wait (vectors_loaded);
    limit = (2.0 * name_q.size() * CLK_PERIOD) + 100.0;
    #(limit);
    stop_with_failure("the run timed out before all vectors were applied");
  end

  // ----------------------------------------
  // stimulus and checking
  // ----------------------------------------

  initial begin
    rst_n = 1'b0;
    links = '0;
    ctrl  = '0;
    load_vectors();
    vectors_loaded = 1'b1;

    repeat (RESET_CYCLES) @(negedge clk);
    // the registers only hold their reset values before the first active edge
    check_reset_state();
    rst_n = 1'b1;

    // inputs change on the falling edge and results are sampled
    // between the rising edge and the next falling edge
    for (int k = 0; k < name_q.size(); k++) begin
      links = link_q[k];
      ctrl  = ctrl_q[k];
      @(posedge clk);
      #(CLK_PERIOD / 2 - 1);
      check_outputs(k);
      @(negedge clk);
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== tb/obs_vectors.txt ====
# name data instr abiim lml lrfodi pc_set pc_mux retire exp_data exp_instr exp_abiim exp_lml exp_lrfodi exp_flag
# link fields are req gnt rvalid rready, exp fields are hex {addr_cont,resp_cont} then count
reset_idle 0000 0000 0000 0000 0000 0 0 0 00 00 00 00 00 0
reset_idle 0000 0000 0000 0000 0000 0 0 0 00 00 00 00 00 0
# address phases waiting for gnt, a different length on every link
addr_cont 1000 1000 1000 0000 1000 0 0 0 20 20 20 00 20 0
addr_cont 1100 1000 1000 1000 1000 0 0 0 01 20 20 20 20 0
addr_cont 0000 1100 1000 1000 1000 0 0 0 01 01 20 20 20 0
addr_cont 0000 0000 1100 1100 1000 0 0 0 01 01 01 01 20 0
addr_cont 0000 0000 0000 0000 1100 0 0 0 01 01 01 01 01 0
addr_cont 0000 0000 0000 0000 0000 0 0 0 01 01 01 01 01 0
# responses waiting for rready, each accepted one drains the count
resp_cont 0010 0010 0010 0000 0011 0 0 0 11 11 11 01 00 0
resp_cont 0011 0010 0010 0010 0000 0 0 0 00 11 11 11 00 0
resp_cont 0000 0011 0010 0011 0000 0 0 0 00 00 11 00 00 0
resp_cont 0000 0000 0011 0000 0000 0 0 0 00 00 00 00 00 0
resp_at_zero 0011 0011 0000 0000 0000 0 0 0 00 00 00 00 00 0
# back to back address phases, then the answers
outst_cnt 1100 1111 0000 0000 0000 0 0 0 01 00 00 00 00 0
outst_cnt 1100 0000 1110 0000 0000 0 0 0 02 00 11 00 00 0
outst_cnt 1100 0000 0011 0000 0000 0 0 0 03 00 00 00 00 0
outst_cnt 1100 0000 0000 0000 0000 0 0 0 04 00 00 00 00 0
outst_cnt 1111 0000 0000 0000 0000 0 0 0 04 00 00 00 00 0
outst_cnt 0011 0000 0000 0000 0000 0 0 0 03 00 00 00 00 0
outst_cnt 0011 0000 0000 0000 0000 0 0 0 02 00 00 00 00 0
outst_cnt 0011 0000 0000 0000 0000 0 0 0 01 00 00 00 00 0
outst_cnt 0011 0000 0000 0000 0000 0 0 0 00 00 00 00 00 0
outst_cnt 0011 0000 0000 0000 0000 0 0 0 00 00 00 00 00 0
# trap window on the data bus, pc_mux 4 exc 5 dbe 6 irq 1 jump
trap_exc 1111 0000 0000 0000 0000 0 0 0 00 00 00 00 00 0
trap_exc 1111 0000 0000 0000 0000 1 4 0 00 00 00 00 00 1
trap_exc 0000 0000 0000 0000 0000 0 0 1 00 00 00 00 00 0
trap_window 0000 0000 0000 0000 0000 1 4 0 00 00 00 00 00 0
trap_window 1111 0000 0000 0000 0000 0 0 0 00 00 00 00 00 0
trap_window 1111 0000 0000 0000 0000 0 0 0 00 00 00 00 00 1
trap_window 0000 0000 0000 0000 0000 0 0 0 00 00 00 00 00 1
trap_window 0000 0000 0000 0000 0000 0 0 1 00 00 00 00 00 0
after_retire 1111 0000 0000 0000 0000 0 0 0 00 00 00 00 00 0
after_retire 1111 0000 0000 0000 0000 0 0 0 00 00 00 00 00 0
jump_only 1111 0000 0000 0000 0000 1 1 0 00 00 00 00 00 0
jump_only 1111 0000 0000 0000 0000 0 0 0 00 00 00 00 00 0
jump_only 0000 0000 0000 0000 0000 0 0 1 00 00 00 00 00 0
trap_irq 1111 0000 0000 0000 0000 0 0 0 00 00 00 00 00 0
trap_irq 1111 0000 0000 0000 0000 1 6 0 00 00 00 00 00 0
trap_irq 1111 0000 0000 0000 0000 0 0 0 00 00 00 00 00 0
trap_irq 0000 0000 0000 0000 0000 0 0 1 00 00 00 00 00 0
trap_dbe 1111 0000 0000 0000 0000 0 0 0 00 00 00 00 00 0
trap_dbe 1111 0000 0000 0000 0000 1 5 0 00 00 00 00 00 1
trap_dbe 1111 0000 0000 0000 0000 0 0 0 00 00 00 00 00 1
trap_dbe 0000 0000 0000 0000 0000 0 0 1 00 00 00 00 00 0
# a trap and a retirement in the same cycle, the trap wins
trap_retire 1111 0000 0000 0000 0000 1 4 1 00 00 00 00 00 0
trap_retire 1111 0000 0000 0000 0000 0 0 0 00 00 00 00 00 1
trap_retire 0000 0000 0000 0000 0000 0 0 1 00 00 00 00 00 0
# seventeen granted requests on the lml link, the count stops at 15
saturate 0000 0000 0000 1100 0000 0 0 0 00 00 00 01 00 0
saturate 0000 0000 0000 1100 0000 0 0 0 00 00 00 02 00 0
saturate 0000 0000 0000 1100 0000 0 0 0 00 00 00 03 00 0
saturate 0000 0000 0000 1100 0000 0 0 0 00 00 00 04 00 0
saturate 0000 0000 0000 1100 0000 0 0 0 00 00 00 05 00 0
saturate 0000 0000 0000 1100 0000 0 0 0 00 00 00 06 00 0
saturate 0000 0000 0000 1100 0000 0 0 0 00 00 00 07 00 0
saturate 0000 0000 0000 1100 0000 0 0 0 00 00 00 08 00 0
saturate 0000 0000 0000 1100 0000 0 0 0 00 00 00 09 00 0
saturate 0000 0000 0000 1100 0000 0 0 0 00 00 00 0a 00 0
saturate 0000 0000 0000 1100 0000 0 0 0 00 00 00 0b 00 0
saturate 0000 0000 0000 1100 0000 0 0 0 00 00 00 0c 00 0
saturate 0000 0000 0000 1100 0000 0 0 0 00 00 00 0d 00 0
saturate 0000 0000 0000 1100 0000 0 0 0 00 00 00 0e 00 0
saturate 0000 0000 0000 1100 0000 0 0 0 00 00 00 0f 00 0
saturate 0000 0000 0000 1100 0000 0 0 0 00 00 00 0f 00 0
saturate 0000 0000 0000 1100 0000 0 0 0 00 00 00 0f 00 0
saturate 0000 0000 0000 0011 0000 0 0 0 00 00 00 0e 00 0
saturate 0000 0000 0000 1000 0000 0 0 0 00 00 00 2e 00 0

// ==== all.f ====
source/obi_mon_pkg.sv
source/core_ctrl_pkg.sv
source/obi_phases_monitor.sv
source/trap_req_tracker.sv
source/obs_support_logic.sv
tb/tb_obs_support_logic.sv

// ==== Makefile ====
TOOL      := verilator
FLAGS     := --binary --timescale 1ns/100ps -j 0
TOP       := tb_obs_support_logic
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

# build the simulation executable from the file list
compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# run from the project root so the vector file path resolves
run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
	  echo "fail message found in $(LOG)"; \
	  exit 1; \
	elif ! grep -q "SIMULATION PASSED" $(LOG); then \
	  echo "no verdict found in $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
